//--- logic/cpr_file.sv
// Reads are combinational; a write lands at the next edge and is not bypassed to the reads
`timescale 1ns/1ps
`default_nettype none

`include "fu_cfg.svh"

module cpr_file (
    input  wire logic                   g_clk,
    input  wire logic                   g_resetn,
    input  wire logic [`FU_CPR_AW-1:0]  rd_addr1, // Read port 1 address
    input  wire logic [`FU_CPR_AW-1:0]  rd_addr2, // Read port 2 address
    input  wire fu_pkg::cpr_wr_t        wr,       // Write port
    output logic [`FU_XLEN-1:0]         rd_data1,
    output logic [`FU_XLEN-1:0]         rd_data2
);
    import fu_pkg::*;

    logic [`FU_XLEN-1:0] regs [`FU_NCPR];      // Register array

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < `FU_NCPR; i++) begin
                regs[i] <= '0;                 // All CPRs start at zero
            end
        end else if (wr.wen) begin
            regs[wr.addr] <= wr.wdata;
        end
    end

    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

endmodule

`default_nettype wire

//--- logic/fu_cfg.svh
// Widths and RNG constants are fixed at build time; FU_RNG_STEPS must stay below 2**8
`ifndef FU_CFG_SVH
`define FU_CFG_SVH

`define FU_XLEN            32            // Data path width
`define FU_CPR_AW          4             // CPR address bits
`define FU_NCPR            16            // Number of CPRs

`define FU_MAJOR_OPCODE    7'h2B         // Encoding bits 6..0 for this unit

`define FU_RNG_TAPS        32'h0040_0007 // Galois feedback mask
`define FU_RNG_RESET_SEED  32'h0000_0001 // Also used in place of a zero seed
`define FU_RNG_STEPS       8             // LFSR steps per RSAMP

`endif

//--- logic/fu_ctrl.sv
// One instruction in flight; ack and rsp are combinational and forced low during reset
`timescale 1ns/1ps
`default_nettype none

`include "fu_cfg.svh"

module fu_ctrl (
    input  wire logic                   g_clk,
    input  wire logic                   g_resetn,
    input  wire logic                   cpu_insn_req,
    input  wire logic                   cpu_insn_ack,
    input  wire fu_pkg::decoded_insn_t  dec,
    input  wire fu_pkg::unit_out_t      palu_out,
    input  wire fu_pkg::unit_out_t      rng_out,
    output logic                        palu_valid,
    output logic                        rng_valid,
    output fu_pkg::cpr_wr_t             cpr_wr,
    output logic                        cop_insn_ack,
    output logic                        cop_insn_rsp,
    output logic                        cop_wen,
    output logic [4:0]                  cop_waddr,
    output logic [`FU_XLEN-1:0]         cop_wdata,
    output fu_pkg::result_t             cop_result
);
    import fu_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE, ST_WAITING, ST_EXECUTING, ST_FINISHED
    } state_t;

    state_t     state;
    state_t     state_nxt;
    logic       ack_nxt;
    logic       rsp_nxt;
    logic       insn_accept;                  // Request taken this cycle
    logic       insn_valid;                   // Instruction live in a unit
    logic       is_rng;                       // RSEED or RSAMP
    logic       fu_done;

    assign insn_accept = cpu_insn_req && (state == ST_WAITING);
    assign insn_valid  = insn_accept || (state == ST_EXECUTING);
    assign is_rng      = (dec.op == OP_RSEED) || (dec.op == OP_RSAMP);

    assign palu_valid  = insn_valid && !dec.illegal && !is_rng; // Dispatch
    assign rng_valid   = insn_valid && !dec.illegal &&  is_rng;

    // Illegal ops finish at once with no unit involved
    assign fu_done = palu_out.done || rng_out.done || (dec.illegal && insn_accept);

    always_comb begin
        state_nxt = state;
        ack_nxt   = 1'b0;
        rsp_nxt   = 1'b0;
        case (state)
            ST_IDLE: begin
                state_nxt = ST_WAITING;
                ack_nxt   = 1'b1;
            end
            ST_WAITING: begin
                ack_nxt = 1'b1;
                if (cpu_insn_req) begin
                    if (fu_done) begin
                        rsp_nxt = 1'b1;           // Single-cycle op
                    end else begin
                        state_nxt = ST_EXECUTING;
                        ack_nxt   = 1'b0;
                    end
                end
            end
            ST_EXECUTING: begin
                if (fu_done) begin
                    state_nxt = ST_FINISHED;
                    rsp_nxt   = 1'b1;
                end
            end
            ST_FINISHED: begin
                if (cpu_insn_ack) begin
                    state_nxt = ST_WAITING;       // Retired
                    ack_nxt   = 1'b1;
                end else begin
                    rsp_nxt   = 1'b1;             // Hold until CPU takes it
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign cop_insn_ack = g_resetn ? ack_nxt : 1'b0;
    assign cop_insn_rsp = g_resetn ? rsp_nxt : 1'b0;

    // CPR write from whichever unit is done
    assign cpr_wr.wen   = (palu_out.done && palu_out.cpr_wen) ||
                          (rng_out.done  && rng_out.cpr_wen);
    assign cpr_wr.addr  = dec.crd;
    assign cpr_wr.wdata = palu_out.done ? palu_out.cpr_wdata : rng_out.cpr_wdata;

    assign cop_wen    = (dec.op == OP_XCR2GPR) && !dec.illegal; // Only GPR writer
    assign cop_waddr  = dec.rd;
    assign cop_wdata  = palu_out.done ? palu_out.gpr_wdata : rng_out.gpr_wdata;
    assign cop_result = dec.illegal ? RES_BAD_INS : RES_SUCCESS;

endmodule

`default_nettype wire

//--- logic/fu_decode.sv
// Purely combinational; bit 24 of the encoding is ignored and ops above RSAMP are illegal
`timescale 1ns/1ps
`default_nettype none

`include "fu_cfg.svh"

module fu_decode (
    input  wire logic [31:0]        insn_enc, // Raw instruction word
    output fu_pkg::decoded_insn_t   dec       // Decoded fields
);
    import fu_pkg::*;

    logic       major_ok;                     // Opcode belongs to this unit
    logic       op_ok;                        // Op field is a defined op_t

    assign major_ok = (insn_enc[6:0] == `FU_MAJOR_OPCODE);
    assign op_ok    = (insn_enc[31:27] <= OP_RSAMP); // Ops are dense from zero

    always_comb begin
        dec.op      = op_t'(insn_enc[31:27]);
        dec.pw      = pw_t'(insn_enc[26:25]);
        dec.crd     = insn_enc[23:20];
        dec.crs1    = insn_enc[19:16];
        dec.crs2    = insn_enc[15:12];
        dec.rd      = insn_enc[11:7];
        dec.illegal = !major_ok || !op_ok;    // Either check fails
    end

endmodule

`default_nettype wire

//--- logic/fu_palu.sv
// Zero-cycle unit; lane arithmetic wraps inside each lane with no carry between lanes
`timescale 1ns/1ps
`default_nettype none

`include "fu_cfg.svh"

module fu_palu (
    input  wire logic                   valid,     // Dispatched this cycle
    input  wire fu_pkg::decoded_insn_t  dec,
    input  wire logic [`FU_XLEN-1:0]    gpr_rs1,   // CPU rs1 value
    input  wire logic [`FU_XLEN-1:0]    crs1_data,
    input  wire logic [`FU_XLEN-1:0]    crs2_data,
    output fu_pkg::unit_out_t           out
);
    import fu_pkg::*;

    logic                   sub;               // PSUB rather than PADD
    logic [`FU_XLEN-1:0]    arith;             // Lane-wise sum or difference
    logic [`FU_XLEN-1:0]    result;
    logic                   writes_cpr;

    assign sub = (dec.op == OP_PSUB);

    always_comb begin
        arith = '0;
        case (dec.pw)
            PW_32: arith = sub ? crs1_data - crs2_data : crs1_data + crs2_data;
            PW_16: for (int i = 0; i < `FU_XLEN / 16; i++) begin
                arith[i*16 +: 16] = sub ? crs1_data[i*16 +: 16] - crs2_data[i*16 +: 16]
                                        : crs1_data[i*16 +: 16] + crs2_data[i*16 +: 16];
            end
            PW_8: for (int i = 0; i < `FU_XLEN / 8; i++) begin
                arith[i*8 +: 8] = sub ? crs1_data[i*8 +: 8] - crs2_data[i*8 +: 8]
                                      : crs1_data[i*8 +: 8] + crs2_data[i*8 +: 8];
            end
            default: for (int i = 0; i < `FU_XLEN / 4; i++) begin // Nibble lanes
                arith[i*4 +: 4] = sub ? crs1_data[i*4 +: 4] - crs2_data[i*4 +: 4]
                                      : crs1_data[i*4 +: 4] + crs2_data[i*4 +: 4];
            end
        endcase
    end

    always_comb begin
        result     = arith;
        writes_cpr = 1'b1;
        case (dec.op)
            OP_GPR2XCR: result = gpr_rs1;       // Move in from the CPU
            OP_XOR:     result = crs1_data ^ crs2_data;
            OP_AND:     result = crs1_data & crs2_data;
            OP_OR:      result = crs1_data | crs2_data;
            OP_PADD,
            OP_PSUB:    result = arith;
            default:    writes_cpr = 1'b0;      // XCR2GPR goes to the GPR only
        endcase
    end

    assign out.done      = valid;
    assign out.cpr_wen   = valid && writes_cpr;
    assign out.cpr_wdata = result;
    assign out.gpr_wdata = crs1_data;          // XCR2GPR source

endmodule

`default_nettype wire

//--- logic/fu_pkg.sv
// Types shared by the FU; field widths follow fu_cfg.svh and the op field is 5 bits wide
`default_nettype none

`include "fu_cfg.svh"

package fu_pkg;

    typedef enum logic [4:0] {
        OP_GPR2XCR = 5'd0,                   // GPR -> CPR
        OP_XCR2GPR = 5'd1,                   // CPR -> GPR
        OP_PADD    = 5'd2,                   // Packed add
        OP_PSUB    = 5'd3,                   // Packed subtract
        OP_XOR     = 5'd4,
        OP_AND     = 5'd5,
        OP_OR      = 5'd6,
        OP_RSEED   = 5'd7,                   // Load LFSR
        OP_RSAMP   = 5'd8                    // Multi-cycle sample
    } op_t;

    typedef enum logic [1:0] {
        PW_32 = 2'd0,
        PW_16 = 2'd1,
        PW_8  = 2'd2,
        PW_4  = 2'd3
    } pw_t;

    typedef enum logic [2:0] {
        RES_SUCCESS = 3'd0,
        RES_BAD_INS = 3'd1
    } result_t;

    typedef struct packed {
        op_t                    op;
        pw_t                    pw;
        logic [`FU_CPR_AW-1:0]  crd;         // CPR destination
        logic [`FU_CPR_AW-1:0]  crs1;
        logic [`FU_CPR_AW-1:0]  crs2;
        logic [4:0]             rd;          // GPR destination
        logic                   illegal;     // Bad major opcode or op
    } decoded_insn_t;

    typedef struct packed {
        logic                   done;        // Unit finished this cycle
        logic                   cpr_wen;
        logic [`FU_XLEN-1:0]    cpr_wdata;
        logic [`FU_XLEN-1:0]    gpr_wdata;
    } unit_out_t;

    typedef struct packed {
        logic                   wen;
        logic [`FU_CPR_AW-1:0]  addr;
        logic [`FU_XLEN-1:0]    wdata;
    } cpr_wr_t;

endpackage

`default_nettype wire

//--- logic/fu_rng.sv
// Not a secure RNG; RSAMP completes FU_RNG_STEPS cycles after accept and RSEED in one cycle
`timescale 1ns/1ps
`default_nettype none

`include "fu_cfg.svh"

module fu_rng (
    input  wire logic                   g_clk,
    input  wire logic                   g_resetn,
    input  wire logic                   valid,     // Held high until done
    input  wire fu_pkg::decoded_insn_t  dec,
    input  wire logic [`FU_XLEN-1:0]    crs1_data, // Seed source
    output fu_pkg::unit_out_t           out
);
    import fu_pkg::*;

    localparam int CNT_W = $clog2(`FU_RNG_STEPS + 1);

    logic [`FU_XLEN-1:0]    lfsr;
    logic [`FU_XLEN-1:0]    lfsr_step;         // One Galois step ahead
    logic [CNT_W-1:0]       step_cnt;          // Steps taken this RSAMP
    logic                   seed;
    logic                   samp;
    logic                   samp_done;

    assign seed      = valid && (dec.op == OP_RSEED);
    assign samp      = valid && (dec.op == OP_RSAMP);
    assign samp_done = samp && (step_cnt == CNT_W'(`FU_RNG_STEPS));

    // Shift left, fold taps back in when the old MSB was set
    assign lfsr_step = {lfsr[`FU_XLEN-2:0], 1'b0} ^ (lfsr[`FU_XLEN-1] ? `FU_RNG_TAPS : '0);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            lfsr     <= `FU_RNG_RESET_SEED;
            step_cnt <= '0;
        end else if (seed) begin
            lfsr     <= (crs1_data == '0) ? `FU_RNG_RESET_SEED : crs1_data; // Never zero
        end else if (samp_done) begin
            step_cnt <= '0;                    // Ready for next sample
        end else if (samp) begin
            lfsr     <= lfsr_step;
            step_cnt <= step_cnt + 1'b1;
        end
    end

    assign out.done      = seed || samp_done;
    assign out.cpr_wen   = samp_done;          // RSEED writes nothing
    assign out.cpr_wdata = lfsr;
    assign out.gpr_wdata = '0;                 // No GPR result from this unit

endmodule

`default_nettype wire

//--- logic/scarv_fu_top.sv
// CPU must hold cpu_insn_enc and cpu_rs1 stable from request until the response is acked
`timescale 1ns/1ps
`default_nettype none

`include "fu_cfg.svh"

module scarv_fu_top (
    input  wire logic                   g_clk,        // Global clock
    input  wire logic                   g_resetn,     // Sync, active low
    input  wire logic                   cpu_insn_req, // Instruction offered
    output logic                        cop_insn_ack, // Ready to accept
    input  wire logic [31:0]            cpu_insn_enc, // Encoded instruction
    input  wire logic [`FU_XLEN-1:0]    cpu_rs1,      // GPR rs1 value
    output logic                        cop_wen,      // GPR write enable
    output logic [4:0]                  cop_waddr,    // GPR write address
    output logic [`FU_XLEN-1:0]         cop_wdata,    // GPR write data
    output fu_pkg::result_t             cop_result,   // Result code
    output logic                        cop_insn_rsp, // Instruction finished
    input  wire logic                   cpu_insn_ack  // Response taken
);
    import fu_pkg::*;

    decoded_insn_t          dec;             // Decoded instruction
    logic [`FU_XLEN-1:0]    crs1_data;       // CPR read port 1
    logic [`FU_XLEN-1:0]    crs2_data;       // CPR read port 2
    logic                   palu_valid;
    logic                   rng_valid;
    unit_out_t              palu_out;
    unit_out_t              rng_out;
    cpr_wr_t                cpr_wr;          // Merged CPR write

    fu_decode i_fu_decode (
        .insn_enc (cpu_insn_enc),
        .dec      (dec)
    );

    cpr_file i_cpr_file (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .rd_addr1 (dec.crs1),
        .rd_addr2 (dec.crs2),
        .wr       (cpr_wr),
        .rd_data1 (crs1_data),
        .rd_data2 (crs2_data)
    );

    fu_palu i_fu_palu (
        .valid     (palu_valid),
        .dec       (dec),
        .gpr_rs1   (cpu_rs1),
        .crs1_data (crs1_data),
        .crs2_data (crs2_data),
        .out       (palu_out)
    );

    fu_rng i_fu_rng (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .valid     (rng_valid),
        .dec       (dec),
        .crs1_data (crs1_data),
        .out       (rng_out)
    );

    fu_ctrl i_fu_ctrl (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .cpu_insn_req (cpu_insn_req),
        .cpu_insn_ack (cpu_insn_ack),
        .dec          (dec),
        .palu_out     (palu_out),
        .rng_out      (rng_out),
        .palu_valid   (palu_valid),
        .rng_valid    (rng_valid),
        .cpr_wr       (cpr_wr),
        .cop_insn_ack (cop_insn_ack),
        .cop_insn_rsp (cop_insn_rsp),
        .cop_wen      (cop_wen),
        .cop_waddr    (cop_waddr),
        .cop_wdata    (cop_wdata),
        .cop_result   (cop_result)
    );

endmodule

`default_nettype wire

//--- scarv_fu_top.f
+incdir+logic
logic/fu_pkg.sv
logic/fu_decode.sv
logic/cpr_file.sv
logic/fu_palu.sv
logic/fu_rng.sv
logic/fu_ctrl.sv
logic/scarv_fu_top.sv
testbench/tb_scarv_fu_top.sv

//--- testbench/tb_scarv_fu_top.sv
// Drives one instruction at a time; the model tracks CPRs and the LFSR and stops at the first error
`timescale 1ns/1ps
`default_nettype none

`include "fu_cfg.svh"

module tb_scarv_fu_top;
    import fu_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 1;                 // Input skew after the rising edge
    localparam int SEED       = 25802;
    localparam int N_RAND     = 4;                 // Repeats per op and width
    localparam int N_INSNS    = 2 * `FU_NCPR + 8 * N_RAND * 4 + 3 * N_RAND * 4
                                + 4 + `FU_NCPR + 4 * 5;

    typedef struct packed {
        logic                   multi;             // RSAMP, response after several cycles
        logic                   cpr_wen;
        logic [`FU_CPR_AW-1:0]  cpr_addr;
        logic [`FU_XLEN-1:0]    cpr_wdata;
        logic                   gpr_wen;
        logic [4:0]             gpr_addr;
        logic [`FU_XLEN-1:0]    gpr_wdata;
        result_t                result;
        logic [`FU_XLEN-1:0]    lfsr_next;         // Model LFSR after retire
    } expect_t;

    logic                   g_clk = 1'b0;
    logic                   g_resetn;
    logic                   cpu_insn_req;
    logic                   cpu_insn_ack;
    logic [31:0]            cpu_insn_enc;
    logic [`FU_XLEN-1:0]    cpu_rs1;
    logic                   cop_insn_ack;
    logic                   cop_insn_rsp;
    logic                   cop_wen;
    logic [4:0]             cop_waddr;
    logic [`FU_XLEN-1:0]    cop_wdata;
    result_t                cop_result;

    logic [`FU_XLEN-1:0]    model_cpr [`FU_NCPR];  // Reference register file
    logic [`FU_XLEN-1:0]    model_lfsr;
    expect_t                expected;              // For the instruction in flight
    int                     issued    = 0;
    int                     rsp_count = 0;
    logic                   rsp_prev  = 1'b0;

    scarv_fu_top i_scarv_fu_top (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .cpu_insn_req (cpu_insn_req),
        .cop_insn_ack (cop_insn_ack),
        .cpu_insn_enc (cpu_insn_enc),
        .cpu_rs1      (cpu_rs1),
        .cop_wen      (cop_wen),
        .cop_waddr    (cop_waddr),
        .cop_wdata    (cop_wdata),
        .cop_result   (cop_result),
        .cop_insn_rsp (cop_insn_rsp),
        .cpu_insn_ack (cpu_insn_ack)
    );

    always #(CLK_PERIOD / 2) g_clk = ~g_clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("ERROR: %s = 0x%08h, expected 0x%08h at %0t", name, got, want, $time);
            $display("Test FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] x);
        return {x[30:0], 1'b0} ^ (x[31] ? `FU_RNG_TAPS : 32'h0); // Galois shift left
    endfunction

    // Lane-wise add or subtract, each lane wraps on its own
    function automatic logic [31:0] lane_arith(input logic [31:0] a, input logic [31:0] b,
                                               input logic [1:0] pw, input logic sub);
        int          w;
        logic [63:0] mask;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] lr;
        logic [31:0] r;
        w    = 32 >> pw;                           // 32, 16, 8 or 4
        mask = (64'd1 << w) - 64'd1;
        r    = '0;
        for (int base = 0; base < 32; base += w) begin
            la = (64'(a) >> base) & mask;
            lb = (64'(b) >> base) & mask;
            lr = (sub ? la - lb : la + lb) & mask; // Drop the lane carry
            r  = r | 32'(lr << base);
        end
        return r;
    endfunction

    function automatic expect_t ref_model(input logic [31:0] enc, input logic [31:0] rs1);
        expect_t     e;
        logic [4:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] l;
        op          = enc[31:27];
        a           = model_cpr[enc[19:16]];
        b           = model_cpr[enc[15:12]];
        e           = '0;
        e.result    = RES_SUCCESS;
        e.cpr_addr  = enc[23:20];
        e.gpr_addr  = enc[11:7];
        e.lfsr_next = model_lfsr;
        if (enc[6:0] != `FU_MAJOR_OPCODE || op > 5'd8) begin
            e.result = RES_BAD_INS;                // No writes at all
        end else begin
            e.cpr_wen = 1'b1;
            case (op)
                OP_GPR2XCR: e.cpr_wdata = rs1;
                OP_XCR2GPR: begin
                    e.cpr_wen   = 1'b0;
                    e.gpr_wen   = 1'b1;
                    e.gpr_wdata = a;
                end
                OP_PADD:    e.cpr_wdata = lane_arith(a, b, enc[26:25], 1'b0);
                OP_PSUB:    e.cpr_wdata = lane_arith(a, b, enc[26:25], 1'b1);
                OP_XOR:     e.cpr_wdata = a ^ b;
                OP_AND:     e.cpr_wdata = a & b;
                OP_OR:      e.cpr_wdata = a | b;
                OP_RSEED: begin
                    e.cpr_wen   = 1'b0;
                    e.lfsr_next = (a == 32'h0) ? `FU_RNG_RESET_SEED : a; // Zero seed replaced
                end
                default: begin                     // RSAMP
                    l = model_lfsr;
                    repeat (`FU_RNG_STEPS) l = lfsr_step(l);
                    e.multi     = 1'b1;
                    e.cpr_wdata = l;
                    e.lfsr_next = l;
                end
            endcase
        end
        return e;
    endfunction

    function automatic logic [31:0] make_enc(input logic [4:0] op, input logic [1:0] pw,
                                             input logic [3:0] crd, input logic [3:0] crs1,
                                             input logic [3:0] crs2, input logic [4:0] rd);
        logic spare;
        spare = 1'($urandom());                    // Bit 24 must not matter
        return {op, pw, spare, crd, crs1, crs2, rd, `FU_MAJOR_OPCODE};
    endfunction

    // Offer one instruction, follow its timing, then update the model
    task automatic issue(input logic [31:0] enc, input logic [31:0] rs1);
        int delay;
        expected     = ref_model(enc, rs1);
        cpu_insn_enc = enc;
        cpu_rs1      = rs1;
        cpu_insn_req = 1'b1;
        issued++;
        @(negedge g_clk);                          // Accept cycle
        check_value("cop_insn_rsp", cop_insn_rsp, !expected.multi);
        check_value("cop_insn_ack", cop_insn_ack, !expected.multi);
        @(posedge g_clk);
        #DRIVE_DLY;
        cpu_insn_req = 1'b0;
        if (expected.multi) begin
            for (int k = 1; k < `FU_RNG_STEPS; k++) begin
                @(negedge g_clk);
                check_value("cop_insn_rsp", cop_insn_rsp, 1'b0);
                check_value("cop_insn_ack", cop_insn_ack, 1'b0);
                @(posedge g_clk);
                #DRIVE_DLY;
            end
            @(negedge g_clk);                      // Response due now
            check_value("cop_insn_rsp", cop_insn_rsp, 1'b1);
            check_value("cop_insn_ack", cop_insn_ack, 1'b0);
            @(posedge g_clk);
            #DRIVE_DLY;
            delay = $urandom_range(3, 0);
            repeat (delay) begin                   // CPU stalls, response holds
                @(negedge g_clk);
                check_value("cop_insn_rsp", cop_insn_rsp, 1'b1);
                check_value("cop_insn_ack", cop_insn_ack, 1'b0);
                @(posedge g_clk);
                #DRIVE_DLY;
            end
            cpu_insn_ack = 1'b1;
            @(negedge g_clk);
            check_value("cop_insn_rsp", cop_insn_rsp, 1'b0);
            check_value("cop_insn_ack", cop_insn_ack, 1'b1);
            @(posedge g_clk);
            #DRIVE_DLY;
            cpu_insn_ack = 1'b0;
        end
        if (expected.cpr_wen) begin
            model_cpr[expected.cpr_addr] = expected.cpr_wdata;
        end
        model_lfsr = expected.lfsr_next;
    endtask

    // Load two operands, run the op, read the destination back
    task automatic run_binary(input logic [4:0] op, input logic [1:0] pw);
        logic [3:0] c1;
        logic [3:0] c2;
        logic [3:0] cd;
        c1 = 4'($urandom_range(15, 0));
        c2 = 4'($urandom_range(15, 0));
        cd = 4'($urandom_range(15, 0));
        issue(make_enc(OP_GPR2XCR, 2'd0, c1, 4'd0, 4'd0, 5'd0), $urandom());
        issue(make_enc(OP_GPR2XCR, 2'd0, c2, 4'd0, 4'd0, 5'd0), $urandom());
        issue(make_enc(op, pw, cd, c1, c2, 5'($urandom())), $urandom());
        issue(make_enc(OP_XCR2GPR, 2'd0, 4'd0, cd, 4'd0, 5'($urandom())), $urandom());
    endtask

    // Compares every response cycle and checks quiet outputs in reset
    always @(negedge g_clk) begin
        if (!g_resetn) begin
            check_value("cop_insn_ack", cop_insn_ack, 1'b0);
            check_value("cop_insn_rsp", cop_insn_rsp, 1'b0);
            rsp_prev <= 1'b0;
        end else begin
            if (cop_insn_rsp) begin
                check_value("cop_result", cop_result, expected.result);
                check_value("cop_wen", cop_wen, expected.gpr_wen);
                if (expected.gpr_wen) begin
                    check_value("cop_waddr", cop_waddr, expected.gpr_addr);
                    check_value("cop_wdata", cop_wdata, expected.gpr_wdata);
                end
                if (!rsp_prev || cop_insn_ack) begin
                    rsp_count++;                   // New response, not a held one
                end
            end
            rsp_prev <= cop_insn_rsp;
        end
    end

    initial begin
        #(N_INSNS * 16 * CLK_PERIOD * 2 + 4 * CLK_PERIOD);
        $display("Timeout: the DUT stopped responding before all instructions retired");
        $display("Test FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        void'($urandom(SEED));
        g_resetn     = 1'b0;
        cpu_insn_req = 1'b0;
        cpu_insn_ack = 1'b0;
        cpu_insn_enc = '0;
        cpu_rs1      = '0;
        model_lfsr   = `FU_RNG_RESET_SEED;
        for (int i = 0; i < `FU_NCPR; i++) begin
            model_cpr[i] = '0;
        end
        repeat (2) @(posedge g_clk);
        #DRIVE_DLY;
        g_resetn = 1'b1;
        @(negedge g_clk);
        check_value("cop_insn_ack", cop_insn_ack, 1'b1); // Ready straight after reset
        @(posedge g_clk);
        #DRIVE_DLY;

        for (int i = 0; i < `FU_NCPR; i++) begin       // Fill every CPR
            issue(make_enc(OP_GPR2XCR, 2'd0, 4'(i), 4'd0, 4'd0, 5'd0), $urandom());
        end
        for (int i = 0; i < `FU_NCPR; i++) begin
            issue(make_enc(OP_XCR2GPR, 2'd0, 4'd0, 4'(i), 4'd0, 5'($urandom())), $urandom());
        end

        for (int pw = 0; pw < 4; pw++) begin
            for (int n = 0; n < 2 * N_RAND; n++) begin
                run_binary((n % 2) ? OP_PSUB : OP_PADD, 2'(pw));
            end
        end
        for (int n = 0; n < N_RAND; n++) begin
            run_binary(OP_XOR, 2'($urandom()));
            run_binary(OP_AND, 2'($urandom()));
            run_binary(OP_OR, 2'($urandom()));
        end

        issue(make_enc(OP_PADD, 2'd0, 4'd3, 4'd1, 4'd2, 5'd4) ^ 32'h1, $urandom());
        issue({make_enc(OP_GPR2XCR, 2'd0, 4'd5, 4'd0, 4'd0, 5'd0)} ^ 32'h18, $urandom());
        issue(make_enc(5'(9 + $urandom_range(22, 0)), 2'd0, 4'd7, 4'd1, 4'd2, 5'd3), 32'h0);
        issue(make_enc(5'd31, 2'd1, 4'd9, 4'd4, 4'd5, 5'd6), $urandom());
        for (int i = 0; i < `FU_NCPR; i++) begin       // Nothing changed
            issue(make_enc(OP_XCR2GPR, 2'd0, 4'd0, 4'(i), 4'd0, 5'($urandom())), $urandom());
        end

        for (int n = 0; n < 4; n++) begin
            logic [3:0] cs;
            logic [3:0] cd;
            cs = 4'($urandom_range(15, 0));
            cd = 4'($urandom_range(15, 0));
            issue(make_enc(OP_GPR2XCR, 2'd0, cs, 4'd0, 4'd0, 5'd0), (n == 0) ? 32'h0 : $urandom());
            issue(make_enc(OP_RSEED, 2'd0, 4'd0, cs, 4'd0, 5'd0), $urandom());
            issue(make_enc(OP_RSAMP, 2'd0, cd, 4'd0, 4'd0, 5'd0), $urandom());
            issue(make_enc(OP_RSAMP, 2'd0, cd, 4'd0, 4'd0, 5'd0), $urandom());
            issue(make_enc(OP_XCR2GPR, 2'd0, 4'd0, cd, 4'd0, 5'($urandom())), $urandom());
        end

        @(negedge g_clk);
        if (rsp_count != issued) begin
            $display("Saw %0d responses for %0d issued instructions", rsp_count, issued);
            $display("Test FAILED");
            $fatal(1, "Response count mismatch");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire
